// File: verilog/cu_link_pkg.sv
`default_nettype none

package cu_link_pkg;

	// id of the engine that issued a command
	typedef logic [1:0] cu_id_t;

	localparam cu_id_t vertex_control_id = 2'd1;
	localparam cu_id_t edge_control_id   = 2'd2;

	typedef logic [63:0] address_t;
	typedef logic [15:0] tag_t;
	typedef logic [63:0] payload_t;

	typedef enum logic {
		cmd_read  = 1'b0,
		cmd_write = 1'b1
	} cmd_kind_t;

	typedef struct packed {
		logic      valid;
		cmd_kind_t cmd_kind;
		cu_id_t    cu_id;
		tag_t      tag;
		address_t  address;
	} command_line_t;

	typedef struct packed {
		logic   valid;
		cu_id_t cu_id;
		tag_t   tag;
	} response_line_t;

	typedef struct packed {
		logic     valid;
		cu_id_t   cu_id;
		tag_t     tag;
		payload_t payload;
	} data_line_t;

	typedef struct packed {
		logic empty;
		logic full;
		logic alfull;
	} buffer_status_t;

	localparam int fifo_depth_vertex = 16;
	localparam int fifo_depth_edge   = 32;
	// free entries left when alfull rises
	localparam int alfull_margin     = 4;

	// valid command line for one engine
	function automatic command_line_t make_command(cmd_kind_t kind, cu_id_t id, tag_t tag,
		address_t address);
		command_line_t line;
		line.valid    = 1'b1;
		line.cmd_kind = kind;
		line.cu_id    = id;
		line.tag      = tag;
		line.address  = address;
		return line;
	endfunction

endpackage

`default_nettype wire

// File: verilog/cu_graph_pkg.sv
`default_nettype none

package cu_graph_pkg;

	// vertex and edge counts, vertex ids
	typedef logic [31:0] count_t;

	// work element descriptor, held by the host for the whole job
	typedef struct packed {
		logic                  valid;
		count_t                num_vertices;
		count_t                num_edges;
		cu_link_pkg::address_t vertex_base;
		cu_link_pkg::address_t edge_base;
		cu_link_pkg::address_t result_base;
	} wed_t;

	typedef struct packed {
		logic   valid;
		count_t vertex_id;
		count_t degree;
		count_t edge_offset;
	} vertex_job_t;

	// record sizes in bytes
	localparam int unsigned vertex_stride = 8;
	localparam int unsigned edge_stride   = 8;
	localparam int unsigned result_stride = 8;

	// jobs waiting between the two engines
	localparam int job_queue_depth = 4;

endpackage

`default_nettype wire

// File: verilog/cu_command_fifo.sv
`default_nettype none

module cu_command_fifo #(
	parameter int depth = 16
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        push,
	input  cu_link_pkg::command_line_t  data_in,
	input  logic                        pop,
	output cu_link_pkg::command_line_t  data_out,
	output cu_link_pkg::buffer_status_t status
);

	cu_link_pkg::command_line_t mem [depth];

	// depth is a power of two, pointers wrap on their own
	logic [$clog2(depth)-1:0]   rd_ptr;
	logic [$clog2(depth)-1:0]   wr_ptr;
	logic [$clog2(depth+1)-1:0] count;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + push - pop;
		end
	end

	// head falls through, valid only while something is stored
	always_comb begin
		data_out       = mem[rd_ptr];
		data_out.valid = (count != '0);
		status.empty   = (count == '0);
		status.full    = (count == depth);
		status.alfull  = (count >= depth - cu_link_pkg::alfull_margin);
	end

	assert property (@(posedge clock) disable iff (!rstn) push |-> !status.full);
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !status.empty);

endmodule

`default_nettype wire

// File: verilog/cu_vertex_job_control.sv
`default_nettype none

module cu_vertex_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  cu_graph_pkg::wed_t          wed,
	input  cu_link_pkg::data_line_t     read_data,
	input  cu_link_pkg::buffer_status_t fifo_status,
	input  logic                        job_request,
	output cu_link_pkg::command_line_t  read_command,
	output cu_graph_pkg::vertex_job_t   job,
	output logic                        job_available,
	output cu_graph_pkg::count_t        filtered_count
);

	typedef enum logic [1:0] {
		idle,
		issue,
		drain
	} vertex_state_t;

	vertex_state_t        state;
	cu_graph_pkg::count_t index;

	cu_graph_pkg::vertex_job_t queue [cu_graph_pkg::job_queue_depth];
	logic [$clog2(cu_graph_pkg::job_queue_depth)-1:0]   head;
	logic [$clog2(cu_graph_pkg::job_queue_depth)-1:0]   tail;
	logic [$clog2(cu_graph_pkg::job_queue_depth+1)-1:0] queue_count;
	// reads still out, each one holds a queue slot
	logic [$clog2(cu_graph_pkg::job_queue_depth+1)-1:0] in_flight;
	logic can_issue;
	logic record_kept;

	assign job_available = (queue_count != '0);
	assign record_kept   = read_data.valid && (read_data.payload[31:0] != '0);
	assign can_issue     = enabled && (state == issue) && !fifo_status.alfull
		&& ((queue_count + in_flight) < cu_graph_pkg::job_queue_depth);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state          <= idle;
			index          <= '0;
			read_command   <= '0;
			filtered_count <= '0;
			head           <= '0;
			tail           <= '0;
			queue_count    <= '0;
			in_flight      <= '0;
		end else if (enabled) begin
			read_command <= '0;
			case (state)
				idle: begin
					index          <= '0;
					filtered_count <= '0;
					if (wed.valid) begin
						state <= (wed.num_vertices == '0) ? drain : issue;
					end
				end
				issue: begin
					if (can_issue) begin
						read_command <= cu_link_pkg::make_command(cu_link_pkg::cmd_read,
							cu_link_pkg::vertex_control_id, cu_link_pkg::tag_t'(index),
							wed.vertex_base
							+ cu_link_pkg::address_t'(index) * cu_graph_pkg::vertex_stride);
						index <= index + 1'b1;
						if (index == wed.num_vertices - 1'b1) begin
							state <= drain;
						end
					end
				end
				drain: begin
					if (!wed.valid) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase

			// zero degree records never become jobs
			if (read_data.valid && !record_kept) begin
				filtered_count <= filtered_count + 1'b1;
			end
			if (record_kept) begin
				tail <= tail + 1'b1;
			end
			if (job_request) begin
				head <= head + 1'b1;
			end
			queue_count <= queue_count + record_kept - job_request;
			in_flight   <= in_flight + can_issue - read_data.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (enabled && record_kept) begin
			queue[tail].valid       <= 1'b1;
			queue[tail].vertex_id   <= cu_graph_pkg::count_t'(read_data.tag);
			queue[tail].degree      <= read_data.payload[31:0];
			queue[tail].edge_offset <= read_data.payload[63:32];
		end
	end

	always_comb begin
		job       = queue[head];
		job.valid = job_available;
	end

	assert property (@(posedge clock) disable iff (!rstn) job_request |-> job_available);

endmodule

`default_nettype wire

// File: verilog/cu_edge_job_control.sv
`default_nettype none

module cu_edge_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  cu_graph_pkg::wed_t          wed,
	input  cu_graph_pkg::vertex_job_t   job,
	input  logic                        job_available,
	output logic                        job_request,
	input  cu_link_pkg::data_line_t     read_data,
	input  cu_link_pkg::response_line_t write_response,
	input  cu_link_pkg::buffer_status_t fifo_status,
	input  logic                        write_alfull,
	output cu_link_pkg::command_line_t  read_command,
	output cu_link_pkg::command_line_t  write_command,
	output cu_link_pkg::data_line_t     write_data,
	output cu_graph_pkg::count_t        vertices_done,
	output cu_graph_pkg::count_t        edges_done
);

	typedef enum logic [2:0] {
		wait_job,
		issue_edges,
		collect,
		write_result,
		wait_ack
	} edge_state_t;

	edge_state_t               state;
	cu_graph_pkg::vertex_job_t current;
	cu_graph_pkg::count_t      issued;
	cu_graph_pkg::count_t      received;
	cu_graph_pkg::count_t      sum;

	assign job_request = enabled && (state == wait_job) && job_available;

	always_ff @(posedge clock) begin
		if (job_request) begin
			current <= job;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state         <= wait_job;
			issued        <= '0;
			received      <= '0;
			sum           <= '0;
			read_command  <= '0;
			write_command <= '0;
			write_data    <= '0;
			vertices_done <= '0;
			edges_done    <= '0;
		end else if (enabled) begin
			read_command  <= '0;
			write_command <= '0;
			write_data    <= '0;
			case (state)
				wait_job: begin
					issued   <= '0;
					received <= '0;
					sum      <= '0;
					if (job_request) begin
						state <= issue_edges;
					end
				end
				issue_edges: begin
					if (!fifo_status.alfull) begin
						read_command <= cu_link_pkg::make_command(cu_link_pkg::cmd_read,
							cu_link_pkg::edge_control_id, cu_link_pkg::tag_t'(issued),
							wed.edge_base + cu_link_pkg::address_t'(current.edge_offset + issued)
							* cu_graph_pkg::edge_stride);
						issued <= issued + 1'b1;
						if (issued == current.degree - 1'b1) begin
							state <= collect;
						end
					end
				end
				collect: begin
					if (received == current.degree) begin
						state <= write_result;
					end
				end
				write_result: begin
					if (!write_alfull) begin
						write_command <= cu_link_pkg::make_command(cu_link_pkg::cmd_write,
							cu_link_pkg::edge_control_id, cu_link_pkg::tag_t'(current.vertex_id),
							wed.result_base + cu_link_pkg::address_t'(current.vertex_id)
							* cu_graph_pkg::result_stride);
						write_data.valid   <= 1'b1;
						write_data.cu_id   <= cu_link_pkg::edge_control_id;
						write_data.tag     <= cu_link_pkg::tag_t'(current.vertex_id);
						write_data.payload <= {current.vertex_id, sum};
						state              <= wait_ack;
					end
				end
				wait_ack: begin
					if (write_response.valid) begin
						vertices_done <= vertices_done + 1'b1;
						state         <= wait_job;
					end
				end
				default: state <= wait_job;
			endcase

			// edges come back in any order
			if (read_data.valid) begin
				sum        <= sum + read_data.payload[31:0];
				received   <= received + 1'b1;
				edges_done <= edges_done + 1'b1;
			end
			if (!wed.valid) begin
				vertices_done <= '0;
				edges_done    <= '0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		!(state == wait_job && read_data.valid));

endmodule

`default_nettype wire

// File: verilog/cu_command_arbiter.sv
`default_nettype none

module cu_command_arbiter (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  cu_link_pkg::command_line_t  vertex_head,
	input  cu_link_pkg::command_line_t  edge_head,
	input  cu_link_pkg::buffer_status_t vertex_status,
	input  cu_link_pkg::buffer_status_t edge_status,
	input  logic                        link_alfull,
	output logic                        vertex_pop,
	output logic                        edge_pop,
	output cu_link_pkg::command_line_t  read_command
);

	logic vertex_request;
	logic edge_request;
	// edge FIFO won the last grant
	logic last_edge;

	assign vertex_request = !vertex_status.empty && !link_alfull;
	assign edge_request   = !edge_status.empty && !link_alfull;

	// each side wins when alone or when its turn has come
	assign vertex_pop = enabled && vertex_request && (!edge_request || last_edge);
	assign edge_pop   = enabled && edge_request && (!vertex_request || !last_edge);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command <= '0;
			last_edge    <= 1'b0;
		end else if (enabled) begin
			if (vertex_pop) begin
				read_command <= vertex_head;
				last_edge    <= 1'b0;
			end else if (edge_pop) begin
				read_command <= edge_head;
				last_edge    <= 1'b1;
			end else begin
				read_command <= '0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) !(vertex_pop && edge_pop));

endmodule

`default_nettype wire

// File: verilog/cu_control.sv
`default_nettype none

module cu_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  cu_graph_pkg::wed_t          wed_in,
	input  cu_link_pkg::response_line_t read_response,
	input  cu_link_pkg::response_line_t write_response,
	input  cu_link_pkg::data_line_t     read_data,
	input  cu_link_pkg::buffer_status_t read_buffer_status,
	input  cu_link_pkg::buffer_status_t write_buffer_status,
	output cu_link_pkg::command_line_t  read_command,
	output cu_link_pkg::command_line_t  write_command,
	output cu_link_pkg::data_line_t     write_data,
	output logic [63:0]                 algorithm_status
);

	// registered inputs
	cu_graph_pkg::wed_t          wed_q;
	cu_link_pkg::response_line_t read_response_q;
	cu_link_pkg::response_line_t write_response_q;
	cu_link_pkg::data_line_t     read_data_q;
	logic                        write_alfull_q;

	// per engine copies after steering
	cu_link_pkg::response_line_t vertex_response;
	cu_link_pkg::response_line_t edge_response;
	cu_link_pkg::data_line_t     vertex_data;
	cu_link_pkg::data_line_t     edge_data;

	cu_link_pkg::command_line_t  vertex_read;
	cu_link_pkg::command_line_t  edge_read;
	cu_link_pkg::command_line_t  vertex_head;
	cu_link_pkg::command_line_t  edge_head;
	cu_link_pkg::buffer_status_t vertex_status;
	cu_link_pkg::buffer_status_t edge_status;
	logic                        vertex_pop;
	logic                        edge_pop;

	cu_graph_pkg::vertex_job_t   job;
	logic                        job_available;
	logic                        job_request;
	cu_link_pkg::command_line_t  engine_write_command;
	cu_link_pkg::data_line_t     engine_write_data;

	cu_graph_pkg::count_t        filtered_count;
	cu_graph_pkg::count_t        vertices_done;
	cu_graph_pkg::count_t        edges_done;
	cu_graph_pkg::count_t        filtered_q;
	cu_graph_pkg::count_t        vertices_done_q;
	cu_graph_pkg::count_t        edges_done_q;
	cu_graph_pkg::count_t        vertices_seen;
	logic                        done;

//////////////////////////////////////////////////////////////////////
// inputs and steering
//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_q            <= '0;
			read_response_q  <= '0;
			write_response_q <= '0;
			read_data_q      <= '0;
			write_alfull_q   <= 1'b0;
			vertex_response  <= '0;
			edge_response    <= '0;
			vertex_data      <= '0;
			edge_data        <= '0;
		end else if (enabled) begin
			wed_q            <= wed_in;
			read_response_q  <= read_response;
			write_response_q <= write_response;
			read_data_q      <= read_data;
			write_alfull_q   <= write_buffer_status.alfull;

			// one pulse, to the engine named in the tag
			vertex_response       <= read_response_q;
			vertex_response.valid <= read_response_q.valid
				&& (read_response_q.cu_id == cu_link_pkg::vertex_control_id);
			edge_response         <= read_response_q;
			edge_response.valid   <= read_response_q.valid
				&& (read_response_q.cu_id == cu_link_pkg::edge_control_id);
			vertex_data           <= read_data_q;
			vertex_data.valid     <= read_data_q.valid
				&& (read_data_q.cu_id == cu_link_pkg::vertex_control_id);
			edge_data             <= read_data_q;
			edge_data.valid       <= read_data_q.valid
				&& (read_data_q.cu_id == cu_link_pkg::edge_control_id);
		end
	end

	// every read response lands at exactly one engine
	assert property (@(posedge clock) disable iff (!rstn)
		enabled && read_response_q.valid |=> vertex_response.valid ^ edge_response.valid);

//////////////////////////////////////////////////////////////////////
// engines, command FIFOs and arbiter
//////////////////////////////////////////////////////////////////////

	cu_vertex_job_control vertex_job_control_i (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.wed           (wed_q),
		.read_data     (vertex_data),
		.fifo_status   (vertex_status),
		.job_request   (job_request),
		.read_command  (vertex_read),
		.job           (job),
		.job_available (job_available),
		.filtered_count(filtered_count)
	);

	cu_edge_job_control edge_job_control_i (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.wed           (wed_q),
		.job           (job),
		.job_available (job_available),
		.job_request   (job_request),
		.read_data     (edge_data),
		.write_response(write_response_q),
		.fifo_status   (edge_status),
		.write_alfull  (write_alfull_q),
		.read_command  (edge_read),
		.write_command (engine_write_command),
		.write_data    (engine_write_data),
		.vertices_done (vertices_done),
		.edges_done    (edges_done)
	);

	cu_command_fifo #(.depth(cu_link_pkg::fifo_depth_vertex)) vertex_fifo_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (enabled && vertex_read.valid),
		.data_in (vertex_read),
		.pop     (vertex_pop),
		.data_out(vertex_head),
		.status  (vertex_status)
	);

	cu_command_fifo #(.depth(cu_link_pkg::fifo_depth_edge)) edge_fifo_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (enabled && edge_read.valid),
		.data_in (edge_read),
		.pop     (edge_pop),
		.data_out(edge_head),
		.status  (edge_status)
	);

	// alfull straight from the port, the grant register is the output stage
	cu_command_arbiter command_arbiter_i (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.vertex_head  (vertex_head),
		.edge_head    (edge_head),
		.vertex_status(vertex_status),
		.edge_status  (edge_status),
		.link_alfull  (read_buffer_status.alfull),
		.vertex_pop   (vertex_pop),
		.edge_pop     (edge_pop),
		.read_command (read_command)
	);

//////////////////////////////////////////////////////////////////////
// done status and outputs
//////////////////////////////////////////////////////////////////////

	assign vertices_seen = filtered_q + vertices_done_q;
	assign done = wed_q.valid && (wed_q.num_vertices == vertices_seen)
		&& (wed_q.num_edges == edges_done_q);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command    <= '0;
			write_data       <= '0;
			algorithm_status <= '0;
			filtered_q       <= '0;
			vertices_done_q  <= '0;
			edges_done_q     <= '0;
		end else if (enabled) begin
			write_command    <= engine_write_command;
			write_data       <= engine_write_data;
			algorithm_status <= done ? {edges_done_q, vertices_seen} : 64'd0;
			filtered_q       <= filtered_count;
			vertices_done_q  <= vertices_done;
			edges_done_q     <= edges_done;
		end
	end

endmodule

`default_nettype wire

// File: verif/cu_host_model.sv
`default_nettype none

module cu_host_model #(
	parameter cu_link_pkg::address_t vertex_base = 64'h0,
	parameter cu_link_pkg::address_t edge_base   = 64'h0
) (
	input  logic                        clock,
	input  logic                        rstn,
	input  cu_link_pkg::command_line_t  read_command,
	input  cu_link_pkg::command_line_t  write_command,
	output cu_link_pkg::response_line_t read_response,
	output cu_link_pkg::response_line_t write_response,
	output cu_link_pkg::data_line_t     read_data,
	output cu_link_pkg::buffer_status_t read_buffer_status,
	output cu_link_pkg::buffer_status_t write_buffer_status
);

	integer                      seed;
	int unsigned                 cycle;
	int unsigned                 last_due;
	int unsigned                 next_due;
	int unsigned                 write_delay;
	cu_link_pkg::data_line_t     line;
	cu_link_pkg::data_line_t     pending [$];
	int unsigned                 due [$];
	cu_link_pkg::response_line_t write_pending;

	// vertex i has degree i mod 4, its edges follow the earlier ones
	function automatic cu_link_pkg::payload_t record_payload(cu_link_pkg::address_t address);
		logic [31:0] index;
		logic [31:0] offset;
		if (address >= edge_base) begin
			index = 32'((address - edge_base) >> 3);
			return {32'd0, index * 32'd3};
		end
		index  = 32'((address - vertex_base) >> 3);
		offset = 32'd0;
		for (int i = 0; i < int'(index); i++) begin
			offset = offset + 32'(i % 4);
		end
		return {offset, index % 32'd4};
	endfunction

	initial begin
		seed                = 32'h6ddd5d8e;
		cycle               = 0;
		last_due            = 0;
		write_pending       = '0;
		write_delay         = 0;
		read_response       = '0;
		write_response      = '0;
		read_data           = '0;
		read_buffer_status  = '0;
		write_buffer_status = '0;
	end

	always @(negedge clock) begin
		if (!rstn) begin
			read_response  <= '0;
			write_response <= '0;
			read_data      <= '0;
			pending.delete();
			due.delete();
			write_pending = '0;
		end else begin
			cycle = cycle + 1;
			read_response  <= '0;
			write_response <= '0;
			read_data      <= '0;
			read_buffer_status.alfull <= (($unsigned($random(seed)) % 32'd4) == 32'd0);

			// returns stay in order, one per cycle
			if (due.size() > 0 && due[0] <= cycle) begin
				line = pending.pop_front();
				void'(due.pop_front());
				read_data     <= line;
				read_response <= '{valid: 1'b1, cu_id: line.cu_id, tag: line.tag};
			end
			if (read_command.valid && read_command.cmd_kind == cu_link_pkg::cmd_read) begin
				line.valid   = 1'b1;
				line.cu_id   = read_command.cu_id;
				line.tag     = read_command.tag;
				line.payload = record_payload(read_command.address);
				next_due = cycle + 1 + ($unsigned($random(seed)) % 32'd6);
				if (next_due <= last_due) begin
					next_due = last_due + 1;
				end
				last_due = next_due;
				pending.push_back(line);
				due.push_back(next_due);
			end

			if (write_pending.valid) begin
				if (write_delay <= 1) begin
					write_response <= write_pending;
					write_pending = '0;
				end else begin
					write_delay = write_delay - 1;
				end
			end
			if (write_command.valid) begin
				write_pending = '{valid: 1'b1, cu_id: write_command.cu_id, tag: write_command.tag};
				write_delay   = 1 + ($unsigned($random(seed)) % 32'd6);
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/cu_control_tb.sv
`default_nettype none

module cu_control_tb;

	localparam cu_link_pkg::address_t vertex_base = 64'h0000_0000_1000_0000;
	localparam cu_link_pkg::address_t edge_base   = 64'h0000_0000_2000_0000;
	localparam cu_link_pkg::address_t result_base = 64'h0000_0000_3000_0000;
	localparam int num_vertices = 20;
	localparam int num_edges    = 30;
	localparam cu_link_pkg::address_t vertex_end = vertex_base + 64'(num_vertices) * 64'd8;
	localparam cu_link_pkg::address_t edge_end   = edge_base + 64'(num_edges) * 64'd8;
	localparam logic [63:0] expected_status = {32'(num_edges), 32'(num_vertices)};
	localparam int done_timeout = 20000;

	logic                        clock;
	logic                        rstn;
	logic                        enabled;
	cu_graph_pkg::wed_t          wed_in;
	cu_link_pkg::response_line_t read_response;
	cu_link_pkg::response_line_t write_response;
	cu_link_pkg::data_line_t     read_data;
	cu_link_pkg::buffer_status_t read_buffer_status;
	cu_link_pkg::buffer_status_t write_buffer_status;
	cu_link_pkg::command_line_t  read_command;
	cu_link_pkg::command_line_t  write_command;
	cu_link_pkg::data_line_t     write_data;
	logic [63:0]                 algorithm_status;

	int                      mismatch_count;
	int                      failure_count;
	int                      write_count;
	int                      expected_writes;
	int                      wait_cycles;
	logic [num_vertices-1:0] written;

	cu_control dut_i (
		.clock              (clock),
		.rstn               (rstn),
		.enabled            (enabled),
		.wed_in             (wed_in),
		.read_response      (read_response),
		.write_response     (write_response),
		.read_data          (read_data),
		.read_buffer_status (read_buffer_status),
		.write_buffer_status(write_buffer_status),
		.read_command       (read_command),
		.write_command      (write_command),
		.write_data         (write_data),
		.algorithm_status   (algorithm_status)
	);

	cu_host_model #(.vertex_base(vertex_base), .edge_base(edge_base)) host_i (
		.clock              (clock),
		.rstn               (rstn),
		.read_command       (read_command),
		.write_command      (write_command),
		.read_response      (read_response),
		.write_response     (write_response),
		.read_data          (read_data),
		.read_buffer_status (read_buffer_status),
		.write_buffer_status(write_buffer_status)
	);

	initial begin
		clock = 1'b0;
	end

	always #2 clock = ~clock;

	function automatic int vertex_degree(int v);
		return v % 4;
	endfunction

	function automatic int first_edge(int v);
		int offset;
		offset = 0;
		for (int i = 0; i < v; i++) begin
			offset = offset + vertex_degree(i);
		end
		return offset;
	endfunction

	// edge j carries destination 3j
	function automatic logic [31:0] expected_sum(int v);
		logic [31:0] sum;
		sum = 32'd0;
		for (int k = 0; k < vertex_degree(v); k++) begin
			sum = sum + 32'(3 * (first_edge(v) + k));
		end
		return sum;
	endfunction

	task automatic report_mismatch(string name, logic [63:0] actual, logic [63:0] expected);
		mismatch_count = mismatch_count + 1;
		$display("MISMATCH %s: got %h expected %h", name, actual, expected);
	endtask

	task automatic report_failure(string text);
		failure_count = failure_count + 1;
		$display("ERROR: %s", text);
	endtask

//////////////////////////////////////////////////////////////////////
// checks on the link
//////////////////////////////////////////////////////////////////////

	task automatic check_result_write();
		int v;
		v = int'(write_command.tag);
		assert (write_data.valid && write_data.tag == write_command.tag)
			else report_failure("write data missing or tagged apart from its command");
		if (v >= num_vertices) begin
			report_failure($sformatf("result write for vertex %0d outside the graph", v));
		end else begin
			assert (write_data.payload[63:32] == 32'(v))
				else report_mismatch("write_data.payload[63:32]",
					64'(write_data.payload[63:32]), 64'(v));
			assert (write_data.payload[31:0] == expected_sum(v))
				else report_mismatch("write_data.payload[31:0]",
					64'(write_data.payload[31:0]), 64'(expected_sum(v)));
			assert (write_command.address == result_base + 64'(v) * 64'd8)
				else report_mismatch("write_command.address", write_command.address,
					result_base + 64'(v) * 64'd8);
			assert (vertex_degree(v) != 0)
				else report_failure($sformatf("vertex %0d has degree zero but was written", v));
			assert (!written[v])
				else report_failure($sformatf("vertex %0d written twice", v));
			written[v]  = 1'b1;
			write_count = write_count + 1;
		end
	endtask

	task automatic check_read_region();
		logic in_vertex;
		logic in_edge;
		in_vertex = read_command.address >= vertex_base && read_command.address < vertex_end;
		in_edge   = read_command.address >= edge_base && read_command.address < edge_end;
		assert (read_command.cmd_kind == cu_link_pkg::cmd_read)
			else report_failure("write kind seen on the read command port");
		if (read_command.cu_id == cu_link_pkg::vertex_control_id) begin
			assert (in_vertex) else report_failure($sformatf(
				"vertex engine read outside the vertex table at %h", read_command.address));
		end else if (read_command.cu_id == cu_link_pkg::edge_control_id) begin
			assert (in_edge) else report_failure($sformatf(
				"edge engine read outside the edge table at %h", read_command.address));
		end else begin
			report_failure($sformatf("read command with unknown cu_id %h", read_command.cu_id));
		end
	endtask

	always @(negedge clock) begin
		if (rstn) begin
			if (write_command.valid) begin
				check_result_write();
			end
			if (read_command.valid) begin
				check_read_region();
			end
			assert (algorithm_status == 64'd0 || algorithm_status == expected_status)
				else report_mismatch("algorithm_status", algorithm_status, expected_status);
			assert (algorithm_status == 64'd0 || write_count == expected_writes)
				else report_failure("status reported before every result was written");
		end
	end

	// grant only in a cycle with link alfull low
	assert property (@(posedge clock) disable iff (!rstn)
		enabled && read_buffer_status.alfull |=> !read_command.valid)
		else report_failure("read command issued after a cycle with read alfull high");

	assert property (@(posedge clock) disable iff (!rstn)
		!enabled |-> !read_command.valid && !write_command.valid && !write_data.valid)
		else report_failure("command valid while the unit is not enabled");

//////////////////////////////////////////////////////////////////////
// stimulus
//////////////////////////////////////////////////////////////////////

	initial begin
		mismatch_count  = 0;
		failure_count   = 0;
		write_count     = 0;
		expected_writes = 0;
		written         = '0;
		rstn            = 1'b0;
		enabled         = 1'b0;
		wed_in          = '0;
		for (int v = 0; v < num_vertices; v++) begin
			if (vertex_degree(v) != 0) begin
				expected_writes = expected_writes + 1;
			end
		end

		repeat (3) @(posedge clock);
		@(negedge clock);
		rstn                = 1'b1;
		wed_in.num_vertices = 32'(num_vertices);
		wed_in.num_edges    = 32'(num_edges);
		wed_in.vertex_base  = vertex_base;
		wed_in.edge_base    = edge_base;
		wed_in.result_base  = result_base;
		wed_in.valid        = 1'b1;
		// valid WED waits while enabled stays low
		repeat (10) @(negedge clock);
		enabled = 1'b1;

		wait_cycles = 0;
		while (algorithm_status == 64'd0 && wait_cycles < done_timeout) begin
			@(negedge clock);
			wait_cycles = wait_cycles + 1;
		end
		if (algorithm_status == 64'd0) begin
			report_failure($sformatf("no completion status after %0d cycles", done_timeout));
		end
		// status holds while the WED stays valid
		for (int i = 0; i < 8; i++) begin
			@(negedge clock);
			assert (algorithm_status == expected_status)
				else report_mismatch("algorithm_status", algorithm_status, expected_status);
		end

		for (int v = 0; v < num_vertices; v++) begin
			assert (written[v] == (vertex_degree(v) != 0))
				else report_failure($sformatf("vertex %0d result write missing", v));
		end

		$display("errors: %0d mismatches, %0d other failures, %0d result writes",
			mismatch_count, failure_count, write_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/cu_link_pkg.sv
verilog/cu_graph_pkg.sv
verilog/cu_command_fifo.sv
verilog/cu_vertex_job_control.sv
verilog/cu_edge_job_control.sv
verilog/cu_command_arbiter.sv
verilog/cu_control.sv
verif/cu_host_model.sv
verif/cu_control_tb.sv
